//--- hw/issue_config_pkg.sv
package issue_config_pkg;

    // Register file and datapath sizes
    parameter int phys_reg_count = 32;
    parameter int data_width = 32;
    parameter int tag_width = $clog2(phys_reg_count);
    parameter int func_width = 3;

    // Defaults for the issue stage parameters
    parameter int default_rs_size = 8;
    parameter int default_num_alu = 2;
    parameter int default_num_mult = 2;
    parameter int default_cdb_width = 2;

endpackage

//--- hw/issue_types_pkg.sv
package issue_types_pkg;

    typedef logic [issue_config_pkg::tag_width-1:0] phys_tag_t;
    typedef logic [issue_config_pkg::data_width-1:0] data_t;
    typedef logic [issue_config_pkg::func_width-1:0] func_t;

    // Execution unit class of a station entry
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_t;

    // One reservation station entry as seen by issue
    typedef struct packed {
        logic      valid;
        phys_tag_t src1;
        logic      src1_ready;
        phys_tag_t src2;
        logic      src2_ready;
        phys_tag_t dest;
        fu_class_t fu_class;
        func_t     func;
    } rs_entry_t;

    // Packet handed to an ALU or multiply unit
    typedef struct packed {
        logic      valid;
        phys_tag_t dest;
        func_t     func;
        data_t     op1;
        data_t     op2;
    } exec_packet_t;

    // One slot of the common data bus
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        data_t     result;
    } cdb_slot_t;

endpackage

//--- hw/priority_select.sv
`timescale 1ns/1ps

module priority_select #(
    parameter int width = 1,
    parameter int reqs = 1
) (
    input  logic [width-1:0]            req,
    output logic [reqs-1:0][width-1:0]  gnt_bus,
    output logic [width-1:0]            gnt
);

    logic [width-1:0] remaining;

    always_comb begin
        remaining = req;
        gnt = '0;
        for (int k = 0; k < reqs; k++) begin
            // Isolate the lowest request still pending
            gnt_bus[k] = remaining & (~remaining + width'(1));
            remaining = remaining & ~gnt_bus[k];
            gnt = gnt | gnt_bus[k];
        end
    end

endmodule

//--- hw/operand_source.sv
`timescale 1ns/1ps

module operand_source #(
    parameter int cdb_width = issue_config_pkg::default_cdb_width
) (
    input  issue_types_pkg::phys_tag_t                    tag,
    input  logic [issue_config_pkg::phys_reg_count-1:0]   complete_list,
    input  issue_types_pkg::data_t                        rf_data,
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb,
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb_next,
    output issue_types_pkg::data_t                        operand
);

    logic                   cdb_hit;
    issue_types_pkg::data_t cdb_value;
    logic                   next_hit;
    issue_types_pkg::data_t next_value;

    // Tag match on both buses, later slots overwrite so the highest index wins
    always_comb begin
        cdb_hit = 1'b0;
        cdb_value = '0;
        next_hit = 1'b0;
        next_value = '0;
        for (int j = 0; j < cdb_width; j++) begin
            if (cdb[j].valid && (cdb[j].tag == tag)) begin
                cdb_hit = 1'b1;
                cdb_value = cdb[j].result;
            end
            if (cdb_next[j].valid && (cdb_next[j].tag == tag)) begin
                next_hit = 1'b1;
                next_value = cdb_next[j].result;
            end
        end
    end

    // Register file first, then current bus, then next bus
    always_comb begin
        if (complete_list[tag]) begin
            operand = rf_data;
        end else if (cdb_hit) begin
            operand = cdb_value;
        end else if (next_hit) begin
            operand = next_value;
        end else begin
            operand = '0;
        end
    end

endmodule

//--- hw/issue_port.sv
`timescale 1ns/1ps

module issue_port #(
    parameter int rs_size = issue_config_pkg::default_rs_size,
    parameter int cdb_width = issue_config_pkg::default_cdb_width
) (
    input  logic [rs_size-1:0]                            entry_gnt,
    input  issue_types_pkg::rs_entry_t [rs_size-1:0]      rs_entries,
    input  logic [issue_config_pkg::phys_reg_count-1:0]   complete_list,
    input  issue_types_pkg::data_t                        rf_data1,
    input  issue_types_pkg::data_t                        rf_data2,
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb,
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb_next,
    output issue_types_pkg::phys_tag_t                    rf_tag1,
    output issue_types_pkg::phys_tag_t                    rf_tag2,
    output issue_types_pkg::exec_packet_t                 packet
);

    localparam int index_width = (rs_size > 1) ? $clog2(rs_size) : 1;

    logic [index_width-1:0]     entry_index;
    logic                       granted;
    issue_types_pkg::rs_entry_t entry;
    issue_types_pkg::data_t     op1;
    issue_types_pkg::data_t     op2;

    // One-hot grant to entry index
    always_comb begin
        entry_index = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (entry_gnt[i]) begin
                entry_index = index_width'(i);
            end
        end
    end

    assign granted = |entry_gnt;
    assign entry = rs_entries[entry_index];

    // Read tags go to the register file only for a granted entry
    assign rf_tag1 = granted ? entry.src1 : '0;
    assign rf_tag2 = granted ? entry.src2 : '0;

    operand_source #(
        .cdb_width(cdb_width)
    ) i_operand_source1 (
        .tag(rf_tag1),
        .complete_list(complete_list),
        .rf_data(rf_data1),
        .cdb(cdb),
        .cdb_next(cdb_next),
        .operand(op1)
    );

    operand_source #(
        .cdb_width(cdb_width)
    ) i_operand_source2 (
        .tag(rf_tag2),
        .complete_list(complete_list),
        .rf_data(rf_data2),
        .cdb(cdb),
        .cdb_next(cdb_next),
        .operand(op2)
    );

    always_comb begin
        packet = '0;
        if (granted) begin
            packet.valid = entry.valid;
            packet.dest = entry.dest;
            packet.func = entry.func;
            packet.op1 = op1;
            packet.op2 = op2;
        end
    end

endmodule

//--- hw/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
    parameter int rs_size = issue_config_pkg::default_rs_size,
    parameter int num_alu = issue_config_pkg::default_num_alu,
    parameter int num_mult = issue_config_pkg::default_num_mult
) (
    input  issue_types_pkg::rs_entry_t [rs_size-1:0]  rs_entries,
    input  logic [num_mult-1:0]                       mult_free,
    input  logic [num_alu-1:0][rs_size-1:0]           alu_port_gnt,
    output logic [rs_size-1:0]                        alu_ready,
    output logic [num_mult-1:0][rs_size-1:0]          mult_unit_gnt,
    output logic [rs_size-1:0]                        rs_issuing
);

    logic [rs_size-1:0]                 mult_ready;
    logic [num_mult-1:0][rs_size-1:0]   mult_entry_bus;
    logic [num_mult-1:0][num_mult-1:0]  free_unit_bus;

    // Both sources ready and the class matches
    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            alu_ready[i] = rs_entries[i].valid && rs_entries[i].src1_ready
                && rs_entries[i].src2_ready && (rs_entries[i].fu_class == issue_types_pkg::fu_alu);
            mult_ready[i] = rs_entries[i].valid && rs_entries[i].src1_ready
                && rs_entries[i].src2_ready && (rs_entries[i].fu_class == issue_types_pkg::fu_mult);
        end
    end

    priority_select #(
        .width(rs_size),
        .reqs(num_mult)
    ) i_mult_entry_select (
        .req(mult_ready),
        .gnt_bus(mult_entry_bus),
        .gnt()
    );

    priority_select #(
        .width(num_mult),
        .reqs(num_mult)
    ) i_free_unit_select (
        .req(mult_free),
        .gnt_bus(free_unit_bus),
        .gnt()
    );

    // n-th ready entry goes to the n-th free unit
    always_comb begin
        mult_unit_gnt = '0;
        for (int n = 0; n < num_mult; n++) begin
            for (int u = 0; u < num_mult; u++) begin
                if (free_unit_bus[n][u]) begin
                    mult_unit_gnt[u] = mult_entry_bus[n];
                end
            end
        end
    end

    always_comb begin
        rs_issuing = '0;
        for (int k = 0; k < num_alu; k++) begin
            rs_issuing = rs_issuing | alu_port_gnt[k];
        end
        for (int u = 0; u < num_mult; u++) begin
            rs_issuing = rs_issuing | mult_unit_gnt[u];
        end
    end

endmodule

//--- hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int rs_size = issue_config_pkg::default_rs_size,
    parameter int num_alu = issue_config_pkg::default_num_alu,
    parameter int num_mult = issue_config_pkg::default_num_mult,
    parameter int cdb_width = issue_config_pkg::default_cdb_width
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [rs_size-1:0]              alu_ready,
    input  logic [num_mult-1:0]             mult_cdb_req,
    output logic [num_alu-1:0][rs_size-1:0] alu_port_gnt,
    output logic [num_mult-1:0]             mult_cdb_gnt,
    output logic [num_alu+num_mult-1:0]     complete_gnt
);

    logic [rs_size-1:0]         alu_cdb_gnt;
    logic [num_alu-1:0]         alu_issue;

    // Multiplier requests sit in the low bits so they win the slots first
    priority_select #(
        .width(num_mult + rs_size),
        .reqs(cdb_width)
    ) i_slot_select (
        .req({alu_ready, mult_cdb_req}),
        .gnt_bus(),
        .gnt({alu_cdb_gnt, mult_cdb_gnt})
    );

    // Slot winners are spread over the ALU ports
    priority_select #(
        .width(rs_size),
        .reqs(num_alu)
    ) i_alu_port_select (
        .req(alu_cdb_gnt),
        .gnt_bus(alu_port_gnt),
        .gnt()
    );

    always_comb begin
        for (int k = 0; k < num_alu; k++) begin
            alu_issue[k] = |alu_port_gnt[k];
        end
    end

    // ALU ports in the low bits, multiply units above
    always_ff @(posedge clock) begin
        if (reset) begin
            complete_gnt <= '0;
        end else begin
            complete_gnt <= {mult_cdb_gnt, alu_issue};
        end
    end

endmodule

//--- hw/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
    parameter int rs_size = issue_config_pkg::default_rs_size,
    parameter int num_alu = issue_config_pkg::default_num_alu,
    parameter int num_mult = issue_config_pkg::default_num_mult,
    parameter int cdb_width = issue_config_pkg::default_cdb_width
) (
    input  logic                                          clock,
    input  logic                                          reset,

    // Reservation station and completion state
    input  issue_types_pkg::rs_entry_t [rs_size-1:0]      rs_entries,
    input  logic [issue_config_pkg::phys_reg_count-1:0]   complete_list,
    output logic [rs_size-1:0]                            rs_issuing,

    // Register file reads, answered in the same cycle
    input  issue_types_pkg::data_t [num_alu-1:0]          alu_rf_data1,
    input  issue_types_pkg::data_t [num_alu-1:0]          alu_rf_data2,
    input  issue_types_pkg::data_t [num_mult-1:0]         mult_rf_data1,
    input  issue_types_pkg::data_t [num_mult-1:0]         mult_rf_data2,
    output issue_types_pkg::phys_tag_t [num_alu-1:0]      alu_rf_tag1,
    output issue_types_pkg::phys_tag_t [num_alu-1:0]      alu_rf_tag2,
    output issue_types_pkg::phys_tag_t [num_mult-1:0]     mult_rf_tag1,
    output issue_types_pkg::phys_tag_t [num_mult-1:0]     mult_rf_tag2,

    // Forwarding buses
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb,
    input  issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb_next,

    // Execution units
    input  logic [num_mult-1:0]                           mult_free,
    input  logic [num_mult-1:0]                           mult_cdb_req,
    output logic [num_mult-1:0]                           mult_cdb_gnt,
    output issue_types_pkg::exec_packet_t [num_alu-1:0]   alu_packets,
    output issue_types_pkg::exec_packet_t [num_mult-1:0]  mult_packets,
    output logic [num_alu+num_mult-1:0]                   complete_gnt
);

    logic [rs_size-1:0]                 alu_ready;
    logic [num_alu-1:0][rs_size-1:0]    alu_port_gnt;
    logic [num_mult-1:0][rs_size-1:0]   mult_unit_gnt;

    issue_select #(
        .rs_size(rs_size),
        .num_alu(num_alu),
        .num_mult(num_mult)
    ) i_issue_select (
        .rs_entries(rs_entries),
        .mult_free(mult_free),
        .alu_port_gnt(alu_port_gnt),
        .alu_ready(alu_ready),
        .mult_unit_gnt(mult_unit_gnt),
        .rs_issuing(rs_issuing)
    );

    cdb_arbiter #(
        .rs_size(rs_size),
        .num_alu(num_alu),
        .num_mult(num_mult),
        .cdb_width(cdb_width)
    ) i_cdb_arbiter (
        .clock(clock),
        .reset(reset),
        .alu_ready(alu_ready),
        .mult_cdb_req(mult_cdb_req),
        .alu_port_gnt(alu_port_gnt),
        .mult_cdb_gnt(mult_cdb_gnt),
        .complete_gnt(complete_gnt)
    );

    for (genvar k = 0; k < num_alu; k++) begin : g_alu_port
        issue_port #(
            .rs_size(rs_size),
            .cdb_width(cdb_width)
        ) i_issue_port (
            .entry_gnt(alu_port_gnt[k]),
            .rs_entries(rs_entries),
            .complete_list(complete_list),
            .rf_data1(alu_rf_data1[k]),
            .rf_data2(alu_rf_data2[k]),
            .cdb(cdb),
            .cdb_next(cdb_next),
            .rf_tag1(alu_rf_tag1[k]),
            .rf_tag2(alu_rf_tag2[k]),
            .packet(alu_packets[k])
        );
    end

    for (genvar u = 0; u < num_mult; u++) begin : g_mult_port
        issue_port #(
            .rs_size(rs_size),
            .cdb_width(cdb_width)
        ) i_issue_port (
            .entry_gnt(mult_unit_gnt[u]),
            .rs_entries(rs_entries),
            .complete_list(complete_list),
            .rf_data1(mult_rf_data1[u]),
            .rf_data2(mult_rf_data2[u]),
            .cdb(cdb),
            .cdb_next(cdb_next),
            .rf_tag1(mult_rf_tag1[u]),
            .rf_tag2(mult_rf_tag2[u]),
            .packet(mult_packets[u])
        );
    end

endmodule

//--- sim/issue_stage_properties.sv
`timescale 1ns/1ps

module issue_stage_properties #(
    parameter int rs_size = issue_config_pkg::default_rs_size,
    parameter int num_alu = issue_config_pkg::default_num_alu,
    parameter int num_mult = issue_config_pkg::default_num_mult,
    parameter int cdb_width = issue_config_pkg::default_cdb_width
) (
    input logic                                         clock,
    input logic                                         reset,
    input logic [num_alu-1:0][rs_size-1:0]              alu_port_gnt,
    input logic [num_mult-1:0][rs_size-1:0]             mult_unit_gnt,
    input logic [rs_size-1:0]                           rs_issuing,
    input issue_types_pkg::exec_packet_t [num_alu-1:0]  alu_packets,
    input issue_types_pkg::exec_packet_t [num_mult-1:0] mult_packets,
    input logic [num_alu+num_mult-1:0]                  complete_gnt
);

    int failures = 0;
    logic [rs_size-1:0] granted_union;
    logic               overlap;
    int                 issued_packets;

    // Union of all port grants, flagging any entry seen twice
    always_comb begin
        granted_union = '0;
        overlap = 1'b0;
        for (int k = 0; k < num_alu; k++) begin
            overlap = overlap | (|(granted_union & alu_port_gnt[k]));
            granted_union = granted_union | alu_port_gnt[k];
        end
        for (int u = 0; u < num_mult; u++) begin
            overlap = overlap | (|(granted_union & mult_unit_gnt[u]));
            granted_union = granted_union | mult_unit_gnt[u];
        end
    end

    // Every issued entry leaves as exactly one valid packet
    always_comb begin
        issued_packets = 0;
        for (int k = 0; k < num_alu; k++) begin
            issued_packets = issued_packets + int'(alu_packets[k].valid);
        end
        for (int u = 0; u < num_mult; u++) begin
            issued_packets = issued_packets + int'(mult_packets[u].valid);
        end
    end

    issuing_is_union: assert property (
        @(posedge clock) disable iff (reset) $countones(rs_issuing) == issued_packets
    ) else begin
        failures++;
        $error("rs_issuing does not match the valid packets of the granted entries");
    end

    single_port_per_entry: assert property (
        @(posedge clock) disable iff (reset) !overlap
    ) else begin
        failures++;
        $error("an entry is granted to more than one port");
    end

    slots_not_exceeded: assert property (
        @(posedge clock) disable iff (reset) $countones(complete_gnt) <= cdb_width
    ) else begin
        failures++;
        $error("complete_gnt holds more grants than bus slots");
    end

    // Register clears on the edge that samples reset
    cleared_after_reset: assert property (
        @(posedge clock) reset |=> complete_gnt == '0
    ) else begin
        failures++;
        $error("complete_gnt is not zero in the cycle after reset");
    end

endmodule

bind issue_stage issue_stage_properties #(
    .rs_size(rs_size),
    .num_alu(num_alu),
    .num_mult(num_mult),
    .cdb_width(cdb_width)
) i_issue_stage_properties (
    .clock(clock),
    .reset(reset),
    .alu_port_gnt(alu_port_gnt),
    .mult_unit_gnt(mult_unit_gnt),
    .rs_issuing(rs_issuing),
    .alu_packets(alu_packets),
    .mult_packets(mult_packets),
    .complete_gnt(complete_gnt)
);

//--- sim/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

    localparam int rs_size = issue_config_pkg::default_rs_size;
    localparam int num_alu = issue_config_pkg::default_num_alu;
    localparam int num_mult = issue_config_pkg::default_num_mult;
    localparam int cdb_width = issue_config_pkg::default_cdb_width;
    localparam int reg_count = issue_config_pkg::phys_reg_count;
    // Reset plus the cycles of every test below
    localparam int test_cycles = 8 + 2 + 3 + 4 + 4 + 2 + 200;

    logic clock;
    logic reset;
    issue_types_pkg::rs_entry_t [rs_size-1:0]      rs_entries;
    logic [reg_count-1:0]                          complete_list;
    issue_types_pkg::data_t [num_alu-1:0]          alu_rf_data1;
    issue_types_pkg::data_t [num_alu-1:0]          alu_rf_data2;
    issue_types_pkg::data_t [num_mult-1:0]         mult_rf_data1;
    issue_types_pkg::data_t [num_mult-1:0]         mult_rf_data2;
    issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb;
    issue_types_pkg::cdb_slot_t [cdb_width-1:0]    cdb_next;
    logic [num_mult-1:0]                           mult_free;
    logic [num_mult-1:0]                           mult_cdb_req;
    logic [rs_size-1:0]                            rs_issuing;
    issue_types_pkg::exec_packet_t [num_alu-1:0]   alu_packets;
    issue_types_pkg::exec_packet_t [num_mult-1:0]  mult_packets;
    issue_types_pkg::phys_tag_t [num_alu-1:0]      alu_rf_tag1;
    issue_types_pkg::phys_tag_t [num_alu-1:0]      alu_rf_tag2;
    issue_types_pkg::phys_tag_t [num_mult-1:0]     mult_rf_tag1;
    issue_types_pkg::phys_tag_t [num_mult-1:0]     mult_rf_tag2;
    logic [num_mult-1:0]                           mult_cdb_gnt;
    logic [num_alu+num_mult-1:0]                   complete_gnt;

    // Expected values from the reference model
    logic [rs_size-1:0]                            exp_issuing;
    issue_types_pkg::exec_packet_t [num_alu-1:0]   exp_alu_packets;
    issue_types_pkg::exec_packet_t [num_mult-1:0]  exp_mult_packets;
    issue_types_pkg::phys_tag_t [num_alu-1:0]      exp_alu_tag1;
    issue_types_pkg::phys_tag_t [num_alu-1:0]      exp_alu_tag2;
    issue_types_pkg::phys_tag_t [num_mult-1:0]     exp_mult_tag1;
    issue_types_pkg::phys_tag_t [num_mult-1:0]     exp_mult_tag2;
    logic [num_mult-1:0]                           exp_mult_cdb_gnt;
    logic [num_alu+num_mult-1:0]                   exp_grant;
    logic [num_alu+num_mult-1:0]                   prev_grant;

    logic [31:0] lfsr;
    int checks;
    int errors;
    int test_start_errors;
    int total_failures;

    issue_stage #(
        .rs_size(rs_size),
        .num_alu(num_alu),
        .num_mult(num_mult),
        .cdb_width(cdb_width)
    ) i_issue_stage (
        .clock(clock),
        .reset(reset),
        .rs_entries(rs_entries),
        .complete_list(complete_list),
        .rs_issuing(rs_issuing),
        .alu_rf_data1(alu_rf_data1),
        .alu_rf_data2(alu_rf_data2),
        .mult_rf_data1(mult_rf_data1),
        .mult_rf_data2(mult_rf_data2),
        .alu_rf_tag1(alu_rf_tag1),
        .alu_rf_tag2(alu_rf_tag2),
        .mult_rf_tag1(mult_rf_tag1),
        .mult_rf_tag2(mult_rf_tag2),
        .cdb(cdb),
        .cdb_next(cdb_next),
        .mult_free(mult_free),
        .mult_cdb_req(mult_cdb_req),
        .mult_cdb_gnt(mult_cdb_gnt),
        .alu_packets(alu_packets),
        .mult_packets(mult_packets),
        .complete_gnt(complete_gnt)
    );

    function automatic issue_types_pkg::data_t rf_value(issue_types_pkg::phys_tag_t tag);
        return issue_types_pkg::data_t'(tag) * 3 + 32'h1000;
    endfunction

    // Register file answers in the same cycle
    always_comb begin
        for (int k = 0; k < num_alu; k++) begin
            alu_rf_data1[k] = rf_value(alu_rf_tag1[k]);
            alu_rf_data2[k] = rf_value(alu_rf_tag2[k]);
        end
        for (int u = 0; u < num_mult; u++) begin
            mult_rf_data1[u] = rf_value(mult_rf_tag1[u]);
            mult_rf_data2[u] = rf_value(mult_rf_tag2[u]);
        end
    end

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #(test_cycles * 4 + 40);
        $display("run stopped by the watchdog after %0d cycles", test_cycles);
        $display("Checks failed");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < count; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic issue_types_pkg::rs_entry_t make_entry(issue_types_pkg::fu_class_t cls,
            int src1, int src2, logic [1:0] ready, int dest);
        issue_types_pkg::rs_entry_t e;
        e.valid = 1'b1;
        e.src1 = issue_types_pkg::phys_tag_t'(src1);
        e.src1_ready = ready[1];
        e.src2 = issue_types_pkg::phys_tag_t'(src2);
        e.src2_ready = ready[0];
        e.dest = issue_types_pkg::phys_tag_t'(dest);
        e.fu_class = cls;
        e.func = issue_types_pkg::func_t'(dest);
        return e;
    endfunction

    function automatic issue_types_pkg::cdb_slot_t make_slot(int tag, int result);
        issue_types_pkg::cdb_slot_t s;
        s.valid = 1'b1;
        s.tag = issue_types_pkg::phys_tag_t'(tag);
        s.result = issue_types_pkg::data_t'(result);
        return s;
    endfunction

    function automatic logic entry_ready(issue_types_pkg::rs_entry_t e,
            issue_types_pkg::fu_class_t cls);
        return e.valid && e.src1_ready && e.src2_ready && (e.fu_class == cls);
    endfunction

    // Register file, then current bus, then next bus, highest slot first
    function automatic issue_types_pkg::data_t expected_operand(issue_types_pkg::phys_tag_t tag);
        if (complete_list[tag]) begin
            return rf_value(tag);
        end
        for (int j = cdb_width - 1; j >= 0; j--) begin
            if (cdb[j].valid && cdb[j].tag == tag) begin
                return cdb[j].result;
            end
        end
        for (int j = cdb_width - 1; j >= 0; j--) begin
            if (cdb_next[j].valid && cdb_next[j].tag == tag) begin
                return cdb_next[j].result;
            end
        end
        return '0;
    endfunction

    function automatic issue_types_pkg::exec_packet_t expected_packet(
            issue_types_pkg::rs_entry_t e);
        issue_types_pkg::exec_packet_t p;
        p.valid = e.valid;
        p.dest = e.dest;
        p.func = e.func;
        p.op1 = expected_operand(e.src1);
        p.op2 = expected_operand(e.src2);
        return p;
    endfunction

    task automatic compute_expected();
        int slots;
        int port;
        int ready_list[$];
        int free_list[$];
        slots = cdb_width;
        port = 0;
        exp_issuing = '0;
        exp_alu_packets = '0;
        exp_mult_packets = '0;
        exp_alu_tag1 = '0;
        exp_alu_tag2 = '0;
        exp_mult_tag1 = '0;
        exp_mult_tag2 = '0;
        exp_mult_cdb_gnt = '0;
        exp_grant = '0;
        for (int u = 0; u < num_mult; u++) begin
            if (mult_cdb_req[u] && slots > 0) begin
                exp_mult_cdb_gnt[u] = 1'b1;
                exp_grant[num_alu + u] = 1'b1;
                slots--;
            end
        end
        for (int i = 0; i < rs_size; i++) begin
            // An ALU entry holding a slot still waits when all ports are taken
            if (entry_ready(rs_entries[i], issue_types_pkg::fu_alu) && slots > 0) begin
                slots--;
                if (port < num_alu) begin
                    exp_alu_tag1[port] = rs_entries[i].src1;
                    exp_alu_tag2[port] = rs_entries[i].src2;
                    exp_alu_packets[port] = expected_packet(rs_entries[i]);
                    exp_grant[port] = 1'b1;
                    exp_issuing[i] = 1'b1;
                    port++;
                end
            end
            if (entry_ready(rs_entries[i], issue_types_pkg::fu_mult)) begin
                ready_list.push_back(i);
            end
        end
        for (int u = 0; u < num_mult; u++) begin
            if (mult_free[u]) begin
                free_list.push_back(u);
            end
        end
        for (int n = 0; n < ready_list.size() && n < free_list.size(); n++) begin
            exp_mult_tag1[free_list[n]] = rs_entries[ready_list[n]].src1;
            exp_mult_tag2[free_list[n]] = rs_entries[ready_list[n]].src2;
            exp_mult_packets[free_list[n]] = expected_packet(rs_entries[ready_list[n]]);
            exp_issuing[ready_list[n]] = 1'b1;
        end
    endtask

    task automatic compare_signal(string name, logic [255:0] got, logic [255:0] expected);
        checks++;
        assert (got === expected) else begin
            $display("mismatch %s: got %0h expected %0h", name, got, expected);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_cycle();
        #2;
        compute_expected();
        compare_signal("rs_issuing", rs_issuing, exp_issuing);
        compare_signal("alu_packets", alu_packets, exp_alu_packets);
        compare_signal("mult_packets", mult_packets, exp_mult_packets);
        compare_signal("alu_rf_tag1", alu_rf_tag1, exp_alu_tag1);
        compare_signal("alu_rf_tag2", alu_rf_tag2, exp_alu_tag2);
        compare_signal("mult_rf_tag1", mult_rf_tag1, exp_mult_tag1);
        compare_signal("mult_rf_tag2", mult_rf_tag2, exp_mult_tag2);
        compare_signal("mult_cdb_gnt", mult_cdb_gnt, exp_mult_cdb_gnt);
        compare_signal("complete_gnt", complete_gnt, prev_grant);
        prev_grant = exp_grant;
    endtask

    task automatic clear_inputs();
        rs_entries = '0;
        complete_list = '1;
        cdb = '0;
        cdb_next = '0;
        mult_free = '0;
        mult_cdb_req = '0;
    endtask

    task automatic randomize_inputs();
        for (int i = 0; i < rs_size; i++) begin
            rs_entries[i].valid = 1'(take_bits(1));
            rs_entries[i].src1 = issue_types_pkg::phys_tag_t'(take_bits(5));
            rs_entries[i].src1_ready = 1'(take_bits(1));
            rs_entries[i].src2 = issue_types_pkg::phys_tag_t'(take_bits(5));
            rs_entries[i].src2_ready = 1'(take_bits(1));
            rs_entries[i].dest = issue_types_pkg::phys_tag_t'(take_bits(5));
            rs_entries[i].fu_class = issue_types_pkg::fu_class_t'(take_bits(1));
            rs_entries[i].func = issue_types_pkg::func_t'(take_bits(3));
        end
        complete_list = take_bits(reg_count);
        for (int j = 0; j < cdb_width; j++) begin
            cdb[j] = {1'(take_bits(1)), 5'(take_bits(5)), take_bits(16)};
            cdb_next[j] = {1'(take_bits(1)), 5'(take_bits(5)), take_bits(16)};
        end
        mult_free = num_mult'(take_bits(num_mult));
        mult_cdb_req = num_mult'(take_bits(num_mult));
    endtask

    task automatic end_test(string name);
        $display("test %-12s done, %0d failures", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin
        lfsr = 32'hd388;
        checks = 0;
        errors = 0;
        test_start_errors = 0;
        prev_grant = '0;
        reset = 1'b1;
        clear_inputs();
        // Completion requests during reset must not reach complete_gnt
        mult_cdb_req = '1;
        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        clear_inputs();

        repeat (2) begin
            next_cycle();
            check_cycle();
        end
        end_test("reset_idle");

        // Entry 0 waits on a source, entry 4 loses to the slot limit
        next_cycle();
        rs_entries[0] = make_entry(issue_types_pkg::fu_alu, 1, 2, 2'b10, 10);
        rs_entries[1] = make_entry(issue_types_pkg::fu_alu, 3, 4, 2'b11, 11);
        rs_entries[2] = make_entry(issue_types_pkg::fu_mult, 5, 6, 2'b11, 12);
        rs_entries[3] = make_entry(issue_types_pkg::fu_alu, 7, 8, 2'b11, 13);
        rs_entries[4] = make_entry(issue_types_pkg::fu_alu, 9, 1, 2'b11, 14);
        check_cycle();
        next_cycle();
        rs_entries[1] = '0;
        check_cycle();
        next_cycle();
        rs_entries = '0;
        rs_entries[6] = make_entry(issue_types_pkg::fu_alu, 20, 21, 2'b11, 22);
        check_cycle();
        end_test("alu_issue");

        next_cycle();
        rs_entries = '0;
        rs_entries[0] = make_entry(issue_types_pkg::fu_alu, 2, 3, 2'b11, 4);
        rs_entries[2] = make_entry(issue_types_pkg::fu_alu, 5, 6, 2'b11, 7);
        rs_entries[5] = make_entry(issue_types_pkg::fu_alu, 8, 9, 2'b11, 10);
        for (int r = 0; r < 4; r++) begin
            if (r > 0) begin
                next_cycle();
            end
            mult_cdb_req = (r == 0) ? 2'b01 : (r == 1) ? 2'b11 : (r == 2) ? 2'b10 : 2'b00;
            check_cycle();
        end
        end_test("contention");

        next_cycle();
        rs_entries = '0;
        mult_cdb_req = '0;
        rs_entries[0] = make_entry(issue_types_pkg::fu_alu, 1, 1, 2'b11, 30);
        rs_entries[2] = make_entry(issue_types_pkg::fu_mult, 2, 3, 2'b11, 31);
        rs_entries[3] = make_entry(issue_types_pkg::fu_mult, 4, 5, 2'b01, 29);
        rs_entries[5] = make_entry(issue_types_pkg::fu_mult, 6, 7, 2'b11, 28);
        rs_entries[7] = make_entry(issue_types_pkg::fu_mult, 8, 9, 2'b11, 27);
        for (int r = 0; r < 4; r++) begin
            if (r > 0) begin
                next_cycle();
            end
            mult_free = num_mult'(r);
            check_cycle();
        end
        end_test("mult_pairing");

        // Tags 5, 6, 7 and 9 are still in flight
        next_cycle();
        rs_entries = '0;
        rs_entries[0] = make_entry(issue_types_pkg::fu_alu, 5, 6, 2'b11, 16);
        rs_entries[1] = make_entry(issue_types_pkg::fu_alu, 7, 9, 2'b11, 17);
        rs_entries[2] = make_entry(issue_types_pkg::fu_mult, 5, 3, 2'b11, 18);
        mult_free = 2'b11;
        complete_list = '1;
        complete_list[5] = 1'b0;
        complete_list[6] = 1'b0;
        complete_list[7] = 1'b0;
        complete_list[9] = 1'b0;
        cdb = {make_slot(5, 'hbbbb), make_slot(5, 'haaaa)};
        cdb_next = {make_slot(7, 'h2222), make_slot(6, 'h1111)};
        check_cycle();
        next_cycle();
        complete_list[5] = 1'b1;
        cdb = {make_slot(6, 'h3333), make_slot(9, 'h4444)};
        cdb_next = {make_slot(9, 'h5555), make_slot(5, 'h6666)};
        cdb[1].valid = 1'b0;
        check_cycle();
        end_test("forwarding");

        repeat (200) begin
            next_cycle();
            randomize_inputs();
            check_cycle();
        end
        end_test("random_mix");

        total_failures = errors + i_issue_stage.i_issue_stage_properties.failures;
        $display("checks run: %0d, failures: %0d", checks, total_failures);
        if (total_failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/issue_config_pkg.sv
hw/issue_types_pkg.sv
hw/priority_select.sv
hw/operand_source.sv
hw/issue_port.sv
hw/issue_select.sv
hw/cdb_arbiter.sv
hw/issue_stage.sv
sim/issue_stage_properties.sv
sim/issue_stage_tb.sv
